// File: all.f
pwm_cfg_pkg.sv
pwm_out_pkg.sv
pwm_shadow_regs.sv
pwm_carrier_counter.sv
deadband_output.sv
deadband_generator.sv
deadband_assertions.sv
tb_deadband_generator.sv

// File: tb_deadband_generator.sv
// random periods are capped at 200 cycles and the watchdog limit assumes that cap
`timescale 1ns/1ps

module tb_deadband_generator;
    import pwm_cfg_pkg::*;
    import pwm_out_pkg::*;

    localparam int max_rand_period = 200;
    localparam int rand_count      = 20;
    // cycles spent per period of a test including settling and syncing
    localparam int repeat_count    = 8;
    localparam int period_sum      = 50 + 50 + 100 + 41 + 40 + 100 + 60 + 7
                                     + rand_count * max_rand_period;
    localparam int watchdog_cycles = period_sum * repeat_count * 2 + 1000;

    logic      clock;
    logic      reset;
    pwm_cfg_t  cfg;
    pwm_pair_t pwm;

    integer seed;
    int     errors;
    int     checks;
    // period the DUT runs once the last cfg is active
    // zero in idle
    int     cur_period;

    deadband_generator dut_i (
        .clock (clock),
        .reset (reset),
        .cfg   (cfg),
        .pwm   (pwm)
    );

    bind deadband_generator deadband_assertions assertions_i (
        .clock         (clock),
        .reset         (reset),
        .pwm           (pwm),
        .carrier       (carrier),
        .active_period (active_period)
    );

    always #2 clock = ~clock;

    // expected thresholds from the switching rule
    function automatic int a_end_rule(input int p, input int d);
        int half;
        half = p / 2;
        if (d >= half) begin
            return 0;
        end
        return half - d;
    endfunction

    function automatic int b_start_rule(input int p, input int d);
        int half;
        half = p / 2;
        if (half + d >= p) begin
            return p;
        end
        return half + d;
    endfunction

    task automatic compare_outputs(input logic exp_a, input logic exp_b, input int phase);
        checks++;
        assert (pwm.a === exp_a) else begin
            errors++;
            $display("FAIL pwm.a at phase %0d: expected %h, got %h", phase, exp_a, pwm.a);
        end
        checks++;
        assert (pwm.b === exp_b) else begin
            errors++;
            $display("FAIL pwm.b at phase %0d: expected %h, got %h", phase, exp_b, pwm.b);
        end
    endtask

    task automatic drive_cfg(input int p, input int d);
        cfg.period   = cnt_width'(p);
        cfg.deadtime = cnt_width'(d);
        cur_period   = (p < 2) ? 0 : p;
    endtask

    // new cfg reaches pwm within one old period plus three cycles
    task automatic apply_and_settle(input int p, input int d);
        int old_period;
        old_period = cur_period;
        drive_cfg(p, d);
        repeat (old_period + 3) @(negedge clock);
    endtask

    task automatic expect_both_low(input int n);
        for (int i = 0; i < n; i++) begin
            compare_outputs(1'b0, 1'b0, i);
            @(negedge clock);
        end
    endtask

    // watch one output for a low to high step for at most limit cycles
    task automatic find_rise(input bit use_b, input int limit, output bit found,
                             output int waited);
        logic prev;
        logic now;
        found  = 1'b0;
        waited = 0;
        prev   = use_b ? pwm.b : pwm.a;
        while (!found && waited < limit) begin
            @(negedge clock);
            waited++;
            now = use_b ? pwm.b : pwm.a;
            if (!prev && now) begin
                found = 1'b1;
            end
            prev = now;
        end
        checks++;
        assert (found) else begin
            errors++;
            $display("no rising edge on pwm.%s within %0d cycles", use_b ? "b" : "a", limit);
        end
    endtask

    // starting at phase start_phase, compare n cycles against the rule
    task automatic follow_pattern(input int p, input int d, input int start_phase,
                                  input int n);
        int a_end;
        int b_start;
        int phase;
        a_end   = a_end_rule(p, d);
        b_start = b_start_rule(p, d);
        for (int i = 0; i < n; i++) begin
            phase = (start_phase + i) % p;
            compare_outputs(phase < a_end, phase >= b_start, phase);
            @(negedge clock);
        end
    endtask

    // apply, sync on whichever output rises, then check n full periods
    task automatic run_pattern(input int p, input int d, input int n);
        bit found;
        int waited;
        int a_end;
        int b_start;
        a_end   = a_end_rule(p, d);
        b_start = b_start_rule(p, d);
        apply_and_settle(p, d);
        if (a_end > 0) begin
            find_rise(1'b0, 2 * p + 4, found, waited);
            if (found) begin
                follow_pattern(p, d, 0, n * p);
            end
        end else if (b_start < p) begin
            find_rise(1'b1, 2 * p + 4, found, waited);
            if (found) begin
                follow_pattern(p, d, b_start, n * p);
            end
        end else begin
            // neither output ever rises
            follow_pattern(p, d, 0, n * p);
        end
    endtask

    task automatic idle_after_reset();
        $display("test: reset and idle");
        expect_both_low(50);
        apply_and_settle(1, 0);
        expect_both_low(50);
    endtask

    task automatic nominal_pattern();
        bit found;
        int waited;
        $display("test: nominal pattern");
        run_pattern(100, 5, 2);
        find_rise(1'b0, 204, found, waited);
        find_rise(1'b0, 204, found, waited);
        if (found) begin
            checks++;
            assert (waited == 100) else begin
                errors++;
                $display("FAIL pwm.a rise spacing: expected %h, got %h", 100, waited);
            end
        end
    endtask

    task automatic saturation();
        $display("test: saturation");
        // a never rises and b is high for a single cycle
        run_pattern(41, 20, 2);
        // both outputs parked low
        run_pattern(40, 25, 2);
    endtask

    task automatic boundary_update();
        $display("test: boundary update");
        run_pattern(100, 5, 1);
        // now at phase 0
        // change cfg halfway through this period
        follow_pattern(100, 5, 0, 50);
        drive_cfg(60, 8);
        follow_pattern(100, 5, 50, 50);
        // new values start exactly at the next period
        follow_pattern(60, 8, 0, 120);
    endtask

    task automatic odd_period();
        $display("test: odd period, zero dead time");
        run_pattern(7, 0, 3);
    endtask

    task automatic random_configs();
        int p;
        int d;
        $display("test: random configurations");
        for (int i = 0; i < rand_count; i++) begin
            p = 2 + ($unsigned($random(seed)) % (max_rand_period - 1));
            d = $unsigned($random(seed)) % p;
            run_pattern(p, d, 2);
        end
    endtask

    initial begin
        int assert_fails;
        seed       = 3156;
        errors     = 0;
        checks     = 0;
        cur_period = 0;
        clock      = 1'b0;
        reset      = 1'b1;
        cfg        = '0;
        repeat (5) @(negedge clock);
        reset = 1'b0;

        idle_after_reset();
        nominal_pattern();
        saturation();
        boundary_update();
        odd_period();
        random_configs();

        assert_fails = dut_i.assertions_i.fail_count;
        $display("checks %0d, check errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("checks %0d, check errors %0d, assertion failures %0d",
                 checks, errors, dut_i.assertions_i.fail_count);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: deadband_assertions.sv
// bound into the top level; count range is checked only outside idle (period of two or more)
`timescale 1ns/1ps

module deadband_assertions (
    input logic                              clock,
    input logic                              reset,
    input pwm_out_pkg::pwm_pair_t            pwm,
    input pwm_out_pkg::carrier_t             carrier,
    input logic [pwm_cfg_pkg::cnt_width-1:0] active_period
);
    import pwm_cfg_pkg::*;

    // failures so far, read by the testbench
    int fail_count = 0;

    // both switches of the half bridge must never be on together
    a_b_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(pwm.a && pwm.b))
        else begin
            $error("pwm.a and pwm.b are high in the same cycle");
            fail_count++;
        end

    reset_low: assert property (@(posedge clock)
        reset |=> (!pwm.a && !pwm.b))
        else begin
            $error("outputs not low in the cycle after reset");
            fail_count++;
        end

    // count restarts at active_period minus one
    count_range: assert property (@(posedge clock) disable iff (reset)
        (active_period >= cnt_width'(2)) |-> (carrier.count < active_period))
        else begin
            $error("carrier count %0d not below active period %0d",
                   carrier.count, active_period);
            fail_count++;
        end

endmodule

// File: deadband_generator.sv
// top level; new cfg shows on pwm after the current period ends, up to one old period plus 3 cycles
`timescale 1ns/1ps

module deadband_generator (
    input  logic                    clock,
    input  logic                    reset,
    input  pwm_cfg_pkg::pwm_cfg_t   cfg,
    output pwm_out_pkg::pwm_pair_t  pwm
);
    import pwm_cfg_pkg::*;
    import pwm_out_pkg::*;

    logic [cnt_width-1:0] active_period;
    pwm_thresh_t          thresh;
    carrier_t             carrier;

    pwm_shadow_regs shadow_i (
        .clock         (clock),
        .reset         (reset),
        .cfg           (cfg),
        .carrier       (carrier),
        .active_period (active_period),
        .thresh        (thresh)
    );

    pwm_carrier_counter carrier_i (
        .clock         (clock),
        .reset         (reset),
        .active_period (active_period),
        .carrier       (carrier)
    );

    deadband_output output_i (
        .clock   (clock),
        .reset   (reset),
        .carrier (carrier),
        .thresh  (thresh),
        .pwm     (pwm)
    );

endmodule

// File: deadband_output.sv
// registered output pair, one cycle behind the count; thresholds must satisfy a_end <= b_start
`timescale 1ns/1ps

module deadband_output (
    input  logic                       clock,
    input  logic                       reset,
    input  pwm_out_pkg::carrier_t      carrier,
    input  pwm_cfg_pkg::pwm_thresh_t   thresh,
    output pwm_out_pkg::pwm_pair_t     pwm
);
    import pwm_out_pkg::*;

    pwm_pair_t next_pwm;

    // a first, then the dead band, then b up to the end of the period
    // idle thresholds keep both comparisons false
    always_comb begin
        next_pwm   = pair_off;
        next_pwm.a = carrier.count < thresh.a_end;
        next_pwm.b = carrier.count >= thresh.b_start;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pwm <= pair_off;
        end else begin
            pwm <= next_pwm;
        end
    end

endmodule

// File: pwm_carrier_counter.sv
// free-running up counter; an active period below two parks it at zero with wrap held high
`timescale 1ns/1ps

module pwm_carrier_counter (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [pwm_cfg_pkg::cnt_width-1:0] active_period,
    output pwm_out_pkg::carrier_t             carrier
);
    import pwm_cfg_pkg::*;
    import pwm_out_pkg::*;

    logic [cnt_width-1:0] last_count;
    logic                 idle;
    logic [cnt_width-1:0] next_count;

    assign idle       = active_period < cnt_width'(2);
    assign last_count = active_period - 1'b1;

    // compare with >= rather than wrap, so the first cycle after idle
    // (count zero, wrap still high) counts on instead of restarting
    always_comb begin
        if (carrier.count >= last_count) begin
            next_count = '0;
        end else begin
            next_count = carrier.count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            carrier <= carrier_idle;
        end else if (idle) begin
            // keep loading configuration every cycle until a real period arrives
            carrier <= carrier_idle;
        end else begin
            carrier.count <= next_count;
            // registered, so wrap lines up with the last count of the period
            carrier.wrap  <= (next_count == last_count);
        end
    end

endmodule

// File: pwm_shadow_regs.sv
// cfg is staged one cycle, then takes effect only at a carrier wrap; thresholds saturate
`timescale 1ns/1ps

module pwm_shadow_regs (
    input  logic                                 clock,
    input  logic                                 reset,
    input  pwm_cfg_pkg::pwm_cfg_t                cfg,
    input  pwm_out_pkg::carrier_t                carrier,
    output logic [pwm_cfg_pkg::cnt_width-1:0]    active_period,
    output pwm_cfg_pkg::pwm_thresh_t             thresh
);
    import pwm_cfg_pkg::*;

    // staged copy of the user configuration
    pwm_cfg_t             staged;

    logic [cnt_width-1:0] half;
    // one extra bit so half plus deadtime never wraps
    logic [cnt_width:0]   upper_sum;
    logic                 staged_idle;
    pwm_thresh_t          next_thresh;

    always_ff @(posedge clock) begin
        if (reset) begin
            staged <= '0;
        end else begin
            staged <= cfg;
        end
    end

    assign half        = staged.period >> 1;
    assign upper_sum   = {1'b0, half} + {1'b0, staged.deadtime};
    assign staged_idle = staged.period < cnt_width'(2);

    always_comb begin
        next_thresh = thresh_idle;
        if (!staged_idle) begin
            // a shrinks to nothing once the dead time eats the whole first half
            if (staged.deadtime >= half) begin
                next_thresh.a_end = '0;
            end else begin
                next_thresh.a_end = half - staged.deadtime;
            end

            // b_start equal to period means b never rises
            if (upper_sum >= {1'b0, staged.period}) begin
                next_thresh.b_start = staged.period;
            end else begin
                next_thresh.b_start = upper_sum[cnt_width-1:0];
            end
        end
    end

    // period and thresholds switch on the same edge, so a running
    // period never sees a mix of old and new values
    always_ff @(posedge clock) begin
        if (reset) begin
            active_period <= '0;
            thresh        <= thresh_idle;
        end else if (carrier.wrap) begin
            active_period <= staged.period;
            thresh        <= next_thresh;
        end
    end

endmodule

// File: pwm_out_pkg.sv
// output side types; the count width is taken from the configuration package
package pwm_out_pkg;

    // complementary output pair for one half bridge
    typedef struct packed {
        logic a;
        logic b;
    } pwm_pair_t;

    // carrier state seen by the shadow registers and the output stage
    // wrap is high on the last count of a period and is held high in idle
    typedef struct packed {
        logic [pwm_cfg_pkg::cnt_width-1:0] count;
        logic                              wrap;
    } carrier_t;

    // state right after reset, counter parked at zero
    localparam carrier_t carrier_idle = '{
        count: '0,
        wrap:  1'b1
    };

    localparam pwm_pair_t pair_off = '{a: 1'b0, b: 1'b0};

endpackage

// File: pwm_cfg_pkg.sv
// configuration side types; counter, period and dead time all share one fixed width
package pwm_cfg_pkg;

    // width of the carrier count, the period and the dead time
    localparam int cnt_width = 10;

    // user configuration, sampled every cycle with no handshake
    // a period below two parks the generator
    typedef struct packed {
        logic [cnt_width-1:0] period;
        logic [cnt_width-1:0] deadtime;
    } pwm_cfg_t;

    // switching points within one period
    // a_end is the first count where a is no longer high
    // b_start is the first count where b is high
    // a_end <= b_start always holds, so a and b never overlap
    typedef struct packed {
        logic [cnt_width-1:0] a_end;
        logic [cnt_width-1:0] b_start;
    } pwm_thresh_t;

    // both outputs held low, used in idle and out of reset
    localparam pwm_thresh_t thresh_idle = '{
        a_end:   '0,
        b_start: '1
    };

endpackage
